// ==== crate_bridge.f ====
hw/crate_bridge_pkg.sv
hw/crate_route_decode.sv
hw/crate_link_sequencer.sv
hw/crate_response_capture.sv
hw/crate_bridge_top.sv
tb/crate_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: crate_bridge

sources:
  # package first, the RTL stages use its names
  - hw/crate_bridge_pkg.sv
  - hw/crate_route_decode.sv
  - hw/crate_link_sequencer.sv
  - hw/crate_response_capture.sv
  - hw/crate_bridge_top.sv
  - target: test
    files:
      - tb/crate_bridge_tb.sv

// ==== tb/crate_bridge_tb.sv ====
`timescale 1ns/100ps
module crate_bridge_tb;

    localparam logic [31:0] SEED      = 32'heebb_f304;
    localparam int          ACK_LIMIT = crate_bridge_pkg::TIMEOUT_CYCLES + 2;
    localparam logic [31:0] ERR_WORD  = crate_bridge_pkg::ERROR_WORD;
    localparam logic [15:0] VALID_ALL = 16'hffff;

    // responder behavior per test
    localparam logic [1:0] ANSWER    = 2'd0;
    localparam logic [1:0] STALL     = 2'd1;
    localparam logic [1:0] WRONG_TAG = 2'd2;

    // type words, space 3 down to space 0
    localparam logic [7:0] TYPES_A = {crate_bridge_pkg::BRIDGE_HK, crate_bridge_pkg::BRIDGE_CTL,
                                      crate_bridge_pkg::BRIDGE_LINK, crate_bridge_pkg::BRIDGE_LINK};
    localparam logic [7:0] TYPES_B = {crate_bridge_pkg::BRIDGE_NONE, crate_bridge_pkg::BRIDGE_LINK,
                                      crate_bridge_pkg::BRIDGE_LINK, crate_bridge_pkg::BRIDGE_LINK};
    localparam logic [7:0] TYPES_C = {crate_bridge_pkg::BRIDGE_HK, crate_bridge_pkg::BRIDGE_CTL,
                                      crate_bridge_pkg::BRIDGE_LINK, crate_bridge_pkg::BRIDGE_HK};
    // no space on the link at all
    localparam logic [7:0] TYPES_D = {crate_bridge_pkg::BRIDGE_HK, crate_bridge_pkg::BRIDGE_CTL,
                                      crate_bridge_pkg::BRIDGE_NONE, crate_bridge_pkg::BRIDGE_CTL};

    typedef struct packed {
        logic [7:0]  types;
        // types driven while the request is open
        logic [7:0]  mid_types;
        logic [15:0] valid;
        logic        we;
        logic [26:0] adr;
        logic [31:0] wdata;
        logic [1:0]  mode;
        logic        chk_data;
        logic [31:0] exp_data;
        logic [3:0]  exp_tmo;
        logic [3:0]  exp_inv;
        logic [1:0]  exp_beats;
    } test_t;

    logic        wb_clk;
    logic        wb_rst;
    logic [7:0]  bridge_type;
    logic [15:0] bridge_valid;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [26:0] adr;
    logic [31:0] dat_w;
    logic [3:0]  sel;
    logic        cmd_ready;
    logic        resp_valid;
    logic [31:0] resp_data;
    logic [1:0]  resp_user;
    logic        ack;
    logic        err;
    logic        rty;
    logic [31:0] dat_r;
    logic        cmd_valid;
    logic [31:0] cmd_data;
    logic        cmd_last;
    logic [1:0]  cmd_dest;
    logic        resp_ready;
    logic [3:0]  timeout_reached;
    logic [3:0]  invalid;

    test_t tests[$];
    string names[$];
    int    errors;

    crate_bridge_top dut (
        .wb_clk_i          (wb_clk),
        .wb_rst_i          (wb_rst),
        .bridge_type_i     (bridge_type),
        .bridge_valid_i    (bridge_valid),
        .bridge_cyc_i      (cyc),
        .bridge_stb_i      (stb),
        .bridge_we_i       (we),
        .bridge_adr_i      (adr),
        .bridge_dat_i      (dat_w),
        .bridge_sel_i      (sel),
        .m_cmd_tready_i    (cmd_ready),
        .s_resp_tvalid_i   (resp_valid),
        .s_resp_tdata_i    (resp_data),
        .s_resp_tuser_i    (resp_user),
        .bridge_ack_o      (ack),
        .bridge_err_o      (err),
        .bridge_rty_o      (rty),
        .bridge_dat_o      (dat_r),
        .m_cmd_tvalid_o    (cmd_valid),
        .m_cmd_tdata_o     (cmd_data),
        .m_cmd_tlast_o     (cmd_last),
        .m_cmd_tdest_o     (cmd_dest),
        .s_resp_tready_o   (resp_ready),
        .timeout_reached_o (timeout_reached),
        .invalid_o         (invalid)
    );

    always #10 wb_clk = ~wb_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // register contents of a remote board, keyed by space and word address
    function automatic logic [31:0] board_data(input logic [1:0] space, input logic [22:0] word);
        return xorshift32(SEED ^ {7'd0, space, word});
    endfunction

    function automatic logic [31:0] word_at(input logic [26:0] a);
        return board_data(a[26:25], a[24:2]);
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    task automatic add_test(input string name, input test_t t);
        names.push_back(name);
        tests.push_back(t);
    endtask

    task automatic load_table();
        add_test("link_write", '{TYPES_A, TYPES_A, VALID_ALL, 1'b1, {2'd1, 25'h0123458},
                 32'hcafe_0001, ANSWER, 1'b0, 32'h0, 4'h0, 4'h0, 2'd2});
        add_test("link_read", '{TYPES_A, TYPES_A, VALID_ALL, 1'b0, {2'd0, 25'h1abcd4c},
                 32'h0, ANSWER, 1'b1, word_at({2'd0, 25'h1abcd4c}), 4'h0, 4'h0, 2'd1});
        add_test("read_wrong_tag", '{TYPES_A, TYPES_A, VALID_ALL, 1'b0, {2'd1, 25'h00007f0},
                 32'h0, WRONG_TAG, 1'b1, word_at({2'd1, 25'h00007f0}), 4'h0, 4'h0, 2'd1});
        // space 2 is a link space but its link valid bit is low
        add_test("invalid_space", '{TYPES_B, TYPES_B, 16'hfdff, 1'b0, {2'd2, 25'h0000010},
                 32'h0, ANSWER, 1'b1, ERR_WORD, 4'h0, 4'b0100, 2'd0});
        add_test("none_space", '{TYPES_B, TYPES_B, VALID_ALL, 1'b0, {2'd3, 25'h0000020},
                 32'h0, ANSWER, 1'b1, ERR_WORD, 4'h0, 4'h0, 2'd0});
        add_test("ctl_write", '{TYPES_A, TYPES_A, VALID_ALL, 1'b1, {2'd2, 25'h0000100},
                 32'h1234_5678, ANSWER, 1'b0, 32'h0, 4'h0, 4'h0, 2'd0});
        add_test("hk_read", '{TYPES_A, TYPES_A, VALID_ALL, 1'b0, {2'd3, 25'h0000104},
                 32'h0, ANSWER, 1'b1, ERR_WORD, 4'h0, 4'h0, 2'd0});
        add_test("stall_read", '{TYPES_A, TYPES_A, VALID_ALL, 1'b0, {2'd0, 25'h0000200},
                 32'h0, STALL, 1'b1, ERR_WORD, 4'b0001, 4'h0, 2'd0});
        add_test("stall_write", '{TYPES_A, TYPES_A, VALID_ALL, 1'b1, {2'd1, 25'h1fffffc},
                 32'h0bad_f00d, STALL, 1'b0, 32'h0, 4'b0010, 4'h0, 2'd0});
        // space 0 turns to housekeeping halfway through a link read
        add_test("type_change_mid", '{TYPES_A, TYPES_C, VALID_ALL, 1'b0, {2'd0, 25'h0000abc},
                 32'h0, ANSWER, 1'b1, word_at({2'd0, 25'h0000abc}), 4'h0, 4'h0, 2'd1});
        add_test("type_after_change", '{TYPES_C, TYPES_C, VALID_ALL, 1'b0, {2'd0, 25'h0000abc},
                 32'h0, ANSWER, 1'b1, ERR_WORD, 4'h0, 4'h0, 2'd0});
        add_test("no_link_drain", '{TYPES_D, TYPES_D, VALID_ALL, 1'b0, {2'd2, 25'h0000040},
                 32'h0, ANSWER, 1'b1, ERR_WORD, 4'h0, 4'h0, 2'd0});
    endtask

    // program type and valid, then leave the bus idle so the latch follows
    task automatic settle(input test_t t, input string name);
        logic no_link;
        no_link = 1'b1;
        for (int s = 0; s < crate_bridge_pkg::N_SPACES; s++) begin
            if (t.types[s*2 +: 2] == crate_bridge_pkg::BRIDGE_LINK) begin
                no_link = 1'b0;
            end
        end
        // type latch, then the registered link summary
        // the first idle cycle also shows that ack lasted a single cycle
        repeat (4) begin
            @(negedge wb_clk);
            bridge_type  = t.types;
            bridge_valid = t.valid;
            assert (!ack && timeout_reached == '0 && invalid == '0) else begin
                errors++;
                $display("test %s: ack or flag raised while the bus was idle", name);
            end
        end
        // response stream drains on its own only without a link space
        check_value(name, "drain ready", {31'd0, no_link}, {31'd0, resp_ready});
    endtask

    // one Wishbone request with the link responder running alongside
    task automatic run_request(input test_t t, input string name, output logic hung);
        int          cycles;
        logic        done;
        logic        resp_accept;
        logic [1:0]  space;
        logic [31:0] rq_data[$];
        logic [1:0]  rq_user[$];
        logic [31:0] beat_data[$];
        logic        beat_last[$];
        logic [1:0]  beat_dest[$];
        crate_bridge_pkg::cmd_word_u hdr;
        space       = t.adr[26:25];
        cycles      = 0;
        done        = 1'b0;
        resp_accept = 1'b0;
        hung        = 1'b0;
        @(negedge wb_clk);
        cyc       = 1'b1;
        stb       = 1'b1;
        we        = t.we;
        adr       = t.adr;
        dat_w     = t.wdata;
        cmd_ready = (t.mode != STALL);
        while (!done && cycles < ACK_LIMIT) begin
            @(negedge wb_clk);
            cycles++;
            bridge_type = t.mid_types;
            // beat taken on the last rising edge
            if (resp_accept) begin
                void'(rq_data.pop_front());
                void'(rq_user.pop_front());
            end
            if (cmd_valid && cmd_ready) begin
                beat_data.push_back(cmd_data);
                beat_last.push_back(cmd_last);
                beat_dest.push_back(cmd_dest);
                hdr.raw = cmd_data;
                // board answers a read header, optionally after a stray beat
                if (beat_data.size() == 1 && hdr.hdr.rd) begin
                    if (t.mode == WRONG_TAG) begin
                        rq_data.push_back(~board_data(cmd_dest, hdr.hdr.addr));
                        rq_user.push_back(cmd_dest + 2'd1);
                    end
                    rq_data.push_back(board_data(cmd_dest, hdr.hdr.addr));
                    rq_user.push_back(cmd_dest);
                end
            end
            resp_valid = (rq_data.size() != 0);
            if (resp_valid) begin
                resp_data = rq_data[0];
                resp_user = rq_user[0];
            end
            resp_accept = resp_valid && resp_ready;
            if (ack) begin
                done = 1'b1;
                if (t.chk_data) begin
                    check_value(name, "read data", t.exp_data, dat_r);
                end
                check_value(name, "timeout flags", {28'd0, t.exp_tmo}, {28'd0, timeout_reached});
                check_value(name, "invalid flags", {28'd0, t.exp_inv}, {28'd0, invalid});
                cyc        = 1'b0;
                stb        = 1'b0;
                we         = 1'b0;
                cmd_ready  = 1'b0;
                resp_valid = 1'b0;
            end else begin
                assert (timeout_reached == '0 && invalid == '0) else begin
                    errors++;
                    $display("test %s: flag raised before ack", name);
                end
            end
        end
        if (!done) begin
            errors++;
            hung = 1'b1;
            $display("test %s: no ack within %0d cycles of the strobe", name, ACK_LIMIT);
        end else begin
            // requests that never touch the link answer one cycle after the strobe
            if (t.exp_beats == 2'd0 && t.mode != STALL) begin
                check_value(name, "ack latency", 32'd1, cycles);
            end
            check_value(name, "command beats", {30'd0, t.exp_beats}, beat_data.size());
            if (beat_data.size() >= 1) begin
                hdr.raw = beat_data[0];
                check_value(name, "header read flag", {31'd0, !t.we}, {31'd0, hdr.hdr.rd});
                check_value(name, "header address", {9'd0, t.adr[24:2]}, {9'd0, hdr.hdr.addr});
                check_value(name, "header zero bits", 32'd0, {24'd0, hdr.hdr.zero, hdr.hdr.pad});
                check_value(name, "header tlast", {31'd0, !t.we}, {31'd0, beat_last[0]});
                check_value(name, "header tdest", {30'd0, space}, {30'd0, beat_dest[0]});
            end
            if (beat_data.size() == 2) begin
                check_value(name, "write data beat", t.wdata, beat_data[1]);
                check_value(name, "data tlast", 32'd1, {31'd0, beat_last[1]});
                check_value(name, "data tdest", {30'd0, space}, {30'd0, beat_dest[1]});
            end
        end
    endtask

    initial begin
        logic hung;
        int   n_run;
        wb_clk       = 1'b0;
        wb_rst       = 1'b1;
        bridge_type  = '0;
        bridge_valid = '0;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        dat_w        = '0;
        sel          = 4'hf;
        cmd_ready    = 1'b0;
        resp_valid   = 1'b0;
        resp_data    = '0;
        resp_user    = '0;
        errors       = 0;
        n_run        = 0;
        hung         = 1'b0;
        load_table();
        repeat (4) @(negedge wb_clk);
        wb_rst = 1'b0;
        assert (!ack && !cmd_valid && timeout_reached == '0 && invalid == '0 && !err && !rty)
            else begin
                errors++;
                $display("bus outputs not quiet after reset");
            end
        for (int i = 0; i < tests.size() && !hung; i++) begin
            settle(tests[i], names[i]);
            run_request(tests[i], names[i], hung);
            n_run++;
        end
        @(negedge wb_clk);
        $display("crate_bridge_tb: %0d tests run, %0d errors", n_run, errors);
        if (errors == 0 && !hung) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== hw/crate_bridge_top.sv ====
`timescale 1ns/100ps
module crate_bridge_top (
    input  logic                                   wb_clk_i,
    input  logic                                   wb_rst_i,
    // two type bits per space
    input  logic [7:0]                             bridge_type_i,
    // four valid bits per space, bit 1 is the link
    input  logic [15:0]                            bridge_valid_i,
    input  logic                                   bridge_cyc_i,
    input  logic                                   bridge_stb_i,
    input  logic                                   bridge_we_i,
    input  logic [crate_bridge_pkg::ADDR_W-1:0]    bridge_adr_i,
    input  logic [crate_bridge_pkg::DATA_W-1:0]    bridge_dat_i,
    // byte selects are ignored, whole words only
    input  logic [3:0]                             bridge_sel_i,
    input  logic                                   m_cmd_tready_i,
    input  logic                                   s_resp_tvalid_i,
    input  logic [crate_bridge_pkg::DATA_W-1:0]    s_resp_tdata_i,
    input  logic [1:0]                             s_resp_tuser_i,
    output logic                                   bridge_ack_o,
    output logic                                   bridge_err_o,
    output logic                                   bridge_rty_o,
    output logic [crate_bridge_pkg::DATA_W-1:0]    bridge_dat_o,
    output logic                                   m_cmd_tvalid_o,
    output logic [crate_bridge_pkg::DATA_W-1:0]    m_cmd_tdata_o,
    output logic                                   m_cmd_tlast_o,
    output logic [1:0]                             m_cmd_tdest_o,
    output logic                                   s_resp_tready_o,
    output logic [crate_bridge_pkg::N_SPACES-1:0]  timeout_reached_o,
    output logic [crate_bridge_pkg::N_SPACES-1:0]  invalid_o
);

    crate_bridge_pkg::route_class_t route;
    logic req;
    logic idle;
    logic no_link;
    logic read_wait;
    logic timeout;
    logic error_resp;
    logic resp_match;
    logic route_invalid;

    assign req           = bridge_cyc_i && bridge_stb_i;
    assign route_invalid = (route == crate_bridge_pkg::ROUTE_INVALID);

    // decode, route per space from the latched types
    crate_route_decode u_decode (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .bridge_type_i  (bridge_type_i),
        .bridge_valid_i (bridge_valid_i),
        .req_i          (req),
        .idle_i         (idle),
        .space_i        (bridge_adr_i[26:25]),
        .route_o        (route),
        .no_link_o      (no_link)
    );

    // execute, drives the command stream and ack
    crate_link_sequencer u_sequencer (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .cyc_i          (bridge_cyc_i),
        .stb_i          (bridge_stb_i),
        .we_i           (bridge_we_i),
        .adr_i          (bridge_adr_i),
        .dat_i          (bridge_dat_i),
        .route_i        (route),
        .m_cmd_tready_i (m_cmd_tready_i),
        .resp_match_i   (resp_match),
        .ack_o          (bridge_ack_o),
        .idle_o         (idle),
        .m_cmd_tvalid_o (m_cmd_tvalid_o),
        .m_cmd_tdata_o  (m_cmd_tdata_o),
        .m_cmd_tlast_o  (m_cmd_tlast_o),
        .m_cmd_tdest_o  (m_cmd_tdest_o),
        .read_wait_o    (read_wait),
        .timeout_o      (timeout),
        .error_resp_o   (error_resp)
    );

    // result, read data and per-space flags
    crate_response_capture u_capture (
        .wb_clk_i          (wb_clk_i),
        .wb_rst_i          (wb_rst_i),
        .s_resp_tvalid_i   (s_resp_tvalid_i),
        .s_resp_tdata_i    (s_resp_tdata_i),
        .s_resp_tuser_i    (s_resp_tuser_i),
        .space_i           (bridge_adr_i[26:25]),
        .read_wait_i       (read_wait),
        .no_link_i         (no_link),
        .timeout_i         (timeout),
        .error_resp_i      (error_resp),
        .invalid_i         (route_invalid),
        .s_resp_tready_o   (s_resp_tready_o),
        .resp_match_o      (resp_match),
        .dat_o             (bridge_dat_o),
        .timeout_reached_o (timeout_reached_o),
        .invalid_o         (invalid_o)
    );

    // failures show up as all ones, never as bus errors
    assign bridge_err_o = 1'b0;
    assign bridge_rty_o = 1'b0;

endmodule

// ==== hw/crate_response_capture.sv ====
`timescale 1ns/100ps
module crate_response_capture (
    input  logic                                   wb_clk_i,
    input  logic                                   wb_rst_i,
    input  logic                                   s_resp_tvalid_i,
    input  logic [crate_bridge_pkg::DATA_W-1:0]    s_resp_tdata_i,
    input  logic [1:0]                             s_resp_tuser_i,
    input  logic [1:0]                             space_i,
    input  logic                                   read_wait_i,
    input  logic                                   no_link_i,
    input  logic                                   timeout_i,
    input  logic                                   error_resp_i,
    input  logic                                   invalid_i,
    output logic                                   s_resp_tready_o,
    output logic                                   resp_match_o,
    output logic [crate_bridge_pkg::DATA_W-1:0]    dat_o,
    output logic [crate_bridge_pkg::N_SPACES-1:0]  timeout_reached_o,
    output logic [crate_bridge_pkg::N_SPACES-1:0]  invalid_o
);

    logic [crate_bridge_pkg::DATA_W-1:0]   dat_q;
    logic [crate_bridge_pkg::N_SPACES-1:0] space_onehot;
    logic [crate_bridge_pkg::N_SPACES-1:0] timeout_q;
    logic [crate_bridge_pkg::N_SPACES-1:0] invalid_q;

    // drain the stream while waiting, or always if no link space exists
    // beats for other spaces are taken and dropped
    assign s_resp_tready_o = read_wait_i || no_link_i;
    assign resp_match_o    = read_wait_i && s_resp_tvalid_i && (s_resp_tuser_i == space_i);

    // read data, valid while ack is up
    always_ff @(posedge wb_clk_i) begin
        if (error_resp_i) begin
            dat_q <= crate_bridge_pkg::ERROR_WORD;
        end else if (resp_match_o) begin
            dat_q <= s_resp_tdata_i;
        end
    end

    assign dat_o = dat_q;

    // one bit per space for the flag outputs
    always_comb begin
        for (int i = 0; i < crate_bridge_pkg::N_SPACES; i++) begin
            space_onehot[i] = (space_i == i);
        end
    end

    // single-cycle flags, made sticky outside the bridge
    // they land together with ack
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            timeout_q <= '0;
            invalid_q <= '0;
        end else begin
            timeout_q <= timeout_i ? space_onehot : '0;
            invalid_q <= (error_resp_i && invalid_i) ? space_onehot : '0;
        end
    end

    assign timeout_reached_o = timeout_q;
    assign invalid_o         = invalid_q;

endmodule

// ==== hw/crate_link_sequencer.sv ====
`timescale 1ns/100ps
module crate_link_sequencer (
    input  logic                                  wb_clk_i,
    input  logic                                  wb_rst_i,
    input  logic                                  cyc_i,
    input  logic                                  stb_i,
    input  logic                                  we_i,
    input  logic [crate_bridge_pkg::ADDR_W-1:0]   adr_i,
    input  logic [crate_bridge_pkg::DATA_W-1:0]   dat_i,
    input  crate_bridge_pkg::route_class_t        route_i,
    input  logic                                  m_cmd_tready_i,
    input  logic                                  resp_match_i,
    output logic                                  ack_o,
    output logic                                  idle_o,
    output logic                                  m_cmd_tvalid_o,
    output logic [crate_bridge_pkg::DATA_W-1:0]   m_cmd_tdata_o,
    output logic                                  m_cmd_tlast_o,
    output logic [1:0]                            m_cmd_tdest_o,
    output logic                                  read_wait_o,
    output logic                                  timeout_o,
    output logic                                  error_resp_o
);

    logic [2:0]                               state_q;
    logic [2:0]                               state_d;
    logic [crate_bridge_pkg::TIMEOUT_W-1:0]   tmo_cnt;
    logic                                     req;
    // high in the states that talk to the link
    logic                                     busy;
    crate_bridge_pkg::cmd_word_u              cmd_word;

    assign req  = cyc_i && stb_i;
    assign busy = (state_q == crate_bridge_pkg::SEQ_HEADER) ||
                  (state_q == crate_bridge_pkg::SEQ_DATA) ||
                  (state_q == crate_bridge_pkg::SEQ_WAIT);

    // down counter, armed when the strobe is first seen
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            tmo_cnt <= '0;
        end else if (state_q == crate_bridge_pkg::SEQ_IDLE && req) begin
            tmo_cnt <= crate_bridge_pkg::TIMEOUT_LOAD;
        end else if (busy && tmo_cnt != '0) begin
            tmo_cnt <= tmo_cnt - 1'b1;
        end
    end

    // last cycle a link request may stay open
    assign timeout_o = busy && (tmo_cnt == '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            crate_bridge_pkg::SEQ_IDLE: begin
                if (req) begin
                    if (route_i == crate_bridge_pkg::ROUTE_LINK) begin
                        state_d = crate_bridge_pkg::SEQ_HEADER;
                    end else begin
                        // nothing to send, answer straight away
                        state_d = crate_bridge_pkg::SEQ_RESPOND;
                    end
                end
            end
            // header always goes out, a write adds a data beat
            crate_bridge_pkg::SEQ_HEADER: begin
                if (timeout_o) begin
                    state_d = crate_bridge_pkg::SEQ_RESPOND;
                end else if (m_cmd_tready_i) begin
                    state_d = we_i ? crate_bridge_pkg::SEQ_DATA : crate_bridge_pkg::SEQ_WAIT;
                end
            end
            crate_bridge_pkg::SEQ_DATA: begin
                if (timeout_o || m_cmd_tready_i) begin
                    state_d = crate_bridge_pkg::SEQ_RESPOND;
                end
            end
            // read waits for a beat tagged with our space
            crate_bridge_pkg::SEQ_WAIT: begin
                if (timeout_o || resp_match_i) begin
                    state_d = crate_bridge_pkg::SEQ_RESPOND;
                end
            end
            crate_bridge_pkg::SEQ_RESPOND: state_d = crate_bridge_pkg::SEQ_IDLE;
            default:                       state_d = crate_bridge_pkg::SEQ_IDLE;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q <= crate_bridge_pkg::SEQ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // error data is loaded on the way into respond
    // covers timeout and every route that never reaches the link
    assign error_resp_o = timeout_o ||
                          (state_q == crate_bridge_pkg::SEQ_IDLE && req &&
                           route_i != crate_bridge_pkg::ROUTE_LINK);

    // header carries the read flag and word address
    always_comb begin
        if (state_q == crate_bridge_pkg::SEQ_DATA) begin
            cmd_word.raw = dat_i;
        end else begin
            cmd_word.hdr.rd   = !we_i;
            cmd_word.hdr.zero = '0;
            cmd_word.hdr.addr = adr_i[24:2];
            cmd_word.hdr.pad  = '0;
        end
    end

    assign m_cmd_tvalid_o = (state_q == crate_bridge_pkg::SEQ_HEADER) ||
                            (state_q == crate_bridge_pkg::SEQ_DATA);
    assign m_cmd_tdata_o  = cmd_word.raw;
    // a read is a single beat
    assign m_cmd_tlast_o  = (state_q == crate_bridge_pkg::SEQ_DATA) || !we_i;
    assign m_cmd_tdest_o  = adr_i[26:25];

    assign ack_o       = (state_q == crate_bridge_pkg::SEQ_RESPOND);
    assign idle_o      = (state_q == crate_bridge_pkg::SEQ_IDLE);
    assign read_wait_o = (state_q == crate_bridge_pkg::SEQ_WAIT);

    // stalled beat must not move, relies on the host holding its request
    assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        m_cmd_tvalid_o && !m_cmd_tready_i && !timeout_o
        |=> m_cmd_tvalid_o && $stable(m_cmd_tdata_o))
        else $error("command beat changed under back-pressure");

    // each ack answers a strobe the host still held on the edge before
    // a second ack cycle would follow a dropped request
    assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ack_o |-> $past(cyc_i && stb_i))
        else $error("ack without an open request");

endmodule

// ==== hw/crate_route_decode.sv ====
`timescale 1ns/100ps
module crate_route_decode (
    input  logic                           wb_clk_i,
    input  logic                           wb_rst_i,
    input  logic [7:0]                     bridge_type_i,
    input  logic [15:0]                    bridge_valid_i,
    input  logic                           req_i,
    input  logic                           idle_i,
    input  logic [1:0]                     space_i,
    output crate_bridge_pkg::route_class_t route_o,
    output logic                           no_link_o
);

    // types as seen by the request in flight
    logic [7:0] type_q;
    // selected space's type and its four valid bits
    logic [1:0] sel_type;
    logic [3:0] sel_valid;
    logic       any_link;
    logic       no_link_q;

    // only follow the type register between requests
    // so a change mid-request waits for the next one
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            type_q <= {crate_bridge_pkg::N_SPACES{crate_bridge_pkg::BRIDGE_NONE}};
        end else if (idle_i && !req_i) begin
            type_q <= bridge_type_i;
        end
    end

    assign sel_type  = type_q[space_i*2 +: 2];
    assign sel_valid = bridge_valid_i[space_i*4 +: 4];

    // any space that still talks over the link
    always_comb begin
        any_link = 1'b0;
        for (int i = 0; i < crate_bridge_pkg::N_SPACES; i++) begin
            if (type_q[i*2 +: 2] == crate_bridge_pkg::BRIDGE_LINK) begin
                any_link = 1'b1;
            end
        end
    end

    // with no link space the response stream is just drained
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            no_link_q <= 1'b1;
        end else begin
            no_link_q <= !any_link;
        end
    end

    assign no_link_o = no_link_q;

    // a space whose link is reported down is refused outright
    always_comb begin
        if (!sel_valid[crate_bridge_pkg::BRIDGE_LINK]) begin
            route_o = crate_bridge_pkg::ROUTE_INVALID;
        end else begin
            case (sel_type)
                crate_bridge_pkg::BRIDGE_NONE: route_o = crate_bridge_pkg::ROUTE_NONE;
                crate_bridge_pkg::BRIDGE_LINK: route_o = crate_bridge_pkg::ROUTE_LINK;
                // control line and housekeeping paths are not built
                crate_bridge_pkg::BRIDGE_CTL:  route_o = crate_bridge_pkg::ROUTE_UNSUPPORTED;
                crate_bridge_pkg::BRIDGE_HK:   route_o = crate_bridge_pkg::ROUTE_UNSUPPORTED;
                default:                       route_o = crate_bridge_pkg::ROUTE_UNSUPPORTED;
            endcase
        end
    end

    // the sequencer steers on this the moment a strobe arrives
    assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        req_i |-> !$isunknown(route_o))
        else $error("route class unknown during a request");

endmodule

// ==== hw/crate_bridge_pkg.sv ====
package crate_bridge_pkg;

    // bridge type codes, two bits per space in the packed type word
    localparam logic [1:0] BRIDGE_NONE = 2'd0;
    localparam logic [1:0] BRIDGE_LINK = 2'd1;
    localparam logic [1:0] BRIDGE_CTL  = 2'd2;
    localparam logic [1:0] BRIDGE_HK   = 2'd3;

    // 27-bit crate space, bits 26:25 pick the board space
    localparam int ADDR_W   = 27;
    localparam int DATA_W   = 32;
    localparam int N_SPACES = 4;

    // cycles from request start until a link request is forced to end
    localparam int TIMEOUT_CYCLES = 64;
    localparam int TIMEOUT_W      = $clog2(TIMEOUT_CYCLES);
    // counter load value, reaches zero on the last allowed cycle
    localparam logic [TIMEOUT_W-1:0] TIMEOUT_LOAD = TIMEOUT_W'(TIMEOUT_CYCLES - 1);

    // what the processor reads back from a failed or unreachable space
    localparam logic [DATA_W-1:0] ERROR_WORD = {DATA_W{1'b1}};

    // sequencer state codes
    localparam logic [2:0] SEQ_IDLE    = 3'd0;
    localparam logic [2:0] SEQ_HEADER  = 3'd1;
    localparam logic [2:0] SEQ_DATA    = 3'd2;
    localparam logic [2:0] SEQ_WAIT    = 3'd3;
    localparam logic [2:0] SEQ_RESPOND = 3'd4;

    // how a request leaves the bridge
    typedef enum logic [1:0] {
        ROUTE_LINK,
        ROUTE_NONE,
        ROUTE_INVALID,
        ROUTE_UNSUPPORTED
    } route_class_t;

    // one command stream word, either a header or raw write data
    typedef union packed {
        struct packed {
            // set for a read, a write follows with a data beat
            logic        rd;
            logic [5:0]  zero;
            // word address inside the board space
            logic [22:0] addr;
            logic [1:0]  pad;
        } hdr;
        logic [DATA_W-1:0] raw;
    } cmd_word_u;

endpackage
